/* include/cmpl_settings.svh */
`ifndef CMPL_SETTINGS_SVH
`define CMPL_SETTINGS_SVH

// datapath width
`define CMPL_XLEN 32

// physical registers, log2 gives the tag width
`define CMPL_PHYS_REGS 64
`define CMPL_TAG_W $clog2(`CMPL_PHYS_REGS)

// reorder buffer entries, power of two so pointers wrap
`define CMPL_ROB_DEPTH 16
`define CMPL_ROB_IDX_W $clog2(`CMPL_ROB_DEPTH)

// writeback lanes, also CDB width and PRF write ports
`define CMPL_WB_WIDTH 4

`endif

/* verilog/rob_ctrl_pkg.sv */
package rob_ctrl_pkg;

    // retire sequencer
    typedef enum logic [1:0] {
        RT_IDLE   = 2'd0,
        RT_RETIRE = 2'd1,
        RT_FLUSH  = 2'd2
    } retire_state_e;

    // jump results write back the link value
    typedef enum logic [1:0] {
        KIND_ALU  = 2'd0,
        KIND_JUMP = 2'd1
    } result_kind_e;

endpackage

/* verilog/cmpl_types_pkg.sv */
`include "cmpl_settings.svh"

package cmpl_types_pkg;

    typedef logic [`CMPL_XLEN-1:0]      data_t;
    typedef logic [`CMPL_TAG_W-1:0]     prf_tag_t;
    typedef logic [`CMPL_ROB_IDX_W-1:0] rob_idx_t;

    typedef struct packed {
        logic                       valid;
        rob_ctrl_pkg::result_kind_e kind;
        rob_idx_t                   rob_idx;
        prf_tag_t                   dest_prf;
        data_t                      value;
        data_t                      link_value;
        logic                       exception;
        logic                       mispred;
    } fu_result_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        prf_tag_t dest_prf;
        data_t    data;
    } lsq_wb_t;

    typedef struct packed {
        logic     valid;
        prf_tag_t phys_tag;
        data_t    value;
    } cdb_entry_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        logic     exception;
        logic     mispred;
        data_t    value;
    } rob_cmpl_t;

    typedef struct packed {
        logic     en;
        prf_tag_t addr;
        data_t    data;
    } prf_wr_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        prf_tag_t dest_prf;
        data_t    value;
        logic     exception;
        logic     mispred;
    } retire_t;

    // wishbone classic, host side
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        prf_tag_t adr;
        data_t    dat;
    } wb_m2s_t;

    typedef struct packed {
        logic  ack;
        logic  err;
        data_t dat;
    } wb_s2m_t;

endpackage

/* verilog/complete_stage.sv */
`timescale 1ns/1ps
`include "cmpl_settings.svh"

module complete_stage (
    input  cmpl_types_pkg::fu_result_t [`CMPL_WB_WIDTH-1:0] fu_res_i,
    input  cmpl_types_pkg::lsq_wb_t                         lsq_wb_i,
    output logic                                            lsq_ready_o,
    output cmpl_types_pkg::prf_wr_t    [`CMPL_WB_WIDTH-1:0] prf_wr_o,
    output cmpl_types_pkg::rob_cmpl_t  [`CMPL_WB_WIDTH-1:0] rob_cmpl_o,
    output cmpl_types_pkg::cdb_entry_t [`CMPL_WB_WIDTH-1:0] cdb_o
);

    logic [`CMPL_WB_WIDTH-1:0] load_sel;

    // lowest idle lane takes the load
    always_comb begin
        logic free_seen;
        free_seen = 1'b0;
        load_sel  = '0;
        for (int i = 0; i < `CMPL_WB_WIDTH; i++) begin
            if (!fu_res_i[i].valid && !free_seen) begin
                load_sel[i] = 1'b1;
                free_seen   = 1'b1;
            end
        end
    end

    assign lsq_ready_o = |load_sel;

    always_comb begin
        cmpl_types_pkg::fu_result_t res;
        cmpl_types_pkg::data_t      val;
        prf_wr_o   = '0;
        rob_cmpl_o = '0;
        cdb_o      = '0;
        for (int i = 0; i < `CMPL_WB_WIDTH; i++) begin
            res = fu_res_i[i];
            if (res.kind == rob_ctrl_pkg::KIND_JUMP) begin
                val = res.link_value;
            end else begin
                val = res.value;
            end
            if (res.valid) begin
                prf_wr_o[i]   = '{en: 1'b1, addr: res.dest_prf, data: val};
                rob_cmpl_o[i] = '{valid: 1'b1, rob_idx: res.rob_idx,
                                  exception: res.exception, mispred: res.mispred,
                                  value: val};
                cdb_o[i]      = '{valid: 1'b1, phys_tag: res.dest_prf, value: val};
            end else if (load_sel[i] && lsq_wb_i.valid) begin
                // loads never fault or mispredict here
                prf_wr_o[i]   = '{en: 1'b1, addr: lsq_wb_i.dest_prf, data: lsq_wb_i.data};
                rob_cmpl_o[i] = '{valid: 1'b1, rob_idx: lsq_wb_i.rob_idx,
                                  exception: 1'b0, mispred: 1'b0, value: lsq_wb_i.data};
                cdb_o[i]      = '{valid: 1'b1, phys_tag: lsq_wb_i.dest_prf,
                                  value: lsq_wb_i.data};
            end
        end
    end

    // renaming hands out unique tags, so merged lanes never collide
    always_comb begin
        for (int i = 0; i < `CMPL_WB_WIDTH; i++) begin
            for (int j = i + 1; j < `CMPL_WB_WIDTH; j++) begin
                assert final (!(prf_wr_o[i].en && prf_wr_o[j].en &&
                                prf_wr_o[i].addr == prf_wr_o[j].addr))
                    else $error("complete_stage: two lanes write the same register");
            end
        end
    end

endmodule

/* verilog/phys_regfile.sv */
`timescale 1ns/1ps
`include "cmpl_settings.svh"

module phys_regfile (
    input  logic                                         clock,
    input  logic                                         rst_n_i,
    input  cmpl_types_pkg::prf_wr_t [`CMPL_WB_WIDTH-1:0] prf_wr_i,
    input  cmpl_types_pkg::wb_m2s_t                      wb_i,
    output cmpl_types_pkg::wb_s2m_t                      wb_o
);

    cmpl_types_pkg::data_t regs_q [`CMPL_PHYS_REGS];
    cmpl_types_pkg::data_t rd_data_q;
    logic                  ack_q;
    logic                  err_q;
    logic                  req;

    // all write ports land at the same edge
    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < `CMPL_PHYS_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int p = 0; p < `CMPL_WB_WIDTH; p++) begin
                if (prf_wr_i[p].en) begin
                    regs_q[prf_wr_i[p].addr] <= prf_wr_i[p].data;
                end
            end
        end
    end

    // new request only once the previous one has been answered
    assign req = wb_i.cyc && wb_i.stb && !ack_q && !err_q;

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= req && !wb_i.we;
            // host writes are refused
            err_q <= req && wb_i.we;
        end
    end

    always_ff @(posedge clock) begin
        if (req && !wb_i.we) begin
            rd_data_q <= regs_q[wb_i.adr];
        end
    end

    assign wb_o = '{ack: ack_q, err: err_q, dat: rd_data_q};

endmodule

/* verilog/rob_ptr_counter.sv */
`timescale 1ns/1ps
`include "cmpl_settings.svh"

module rob_ptr_counter (
    input  logic                     clock,
    input  logic                     rst_n_i,
    input  logic                     alloc_i,
    input  logic                     retire_i,
    input  logic                     flush_i,
    output cmpl_types_pkg::rob_idx_t head_o,
    output cmpl_types_pkg::rob_idx_t tail_o,
    output logic                     full_o,
    output logic                     empty_o
);

    cmpl_types_pkg::rob_idx_t head_q;
    cmpl_types_pkg::rob_idx_t tail_q;
    logic [`CMPL_ROB_IDX_W:0] count_q;

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (retire_i) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc_i, retire_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign head_o  = head_q;
    assign tail_o  = tail_q;
    assign full_o  = (count_q == `CMPL_ROB_DEPTH);
    assign empty_o = (count_q == '0);

    a_count_bound: assert property (@(posedge clock) disable iff (!rst_n_i)
        count_q <= `CMPL_ROB_DEPTH)
        else $error("rob_ptr_counter: occupancy above ROB depth");

endmodule

/* verilog/rob_done_table.sv */
`timescale 1ns/1ps
`include "cmpl_settings.svh"

module rob_done_table (
    input  logic                                           clock,
    input  logic                                           rst_n_i,
    input  logic                                           alloc_i,
    input  cmpl_types_pkg::rob_idx_t                       alloc_idx_i,
    input  cmpl_types_pkg::prf_tag_t                       alloc_dest_prf_i,
    input  cmpl_types_pkg::rob_cmpl_t [`CMPL_WB_WIDTH-1:0] rob_cmpl_i,
    input  logic                                           flush_i,
    input  cmpl_types_pkg::rob_idx_t                       head_idx_i,
    output cmpl_types_pkg::retire_t                        head_o
);

    logic [`CMPL_ROB_DEPTH-1:0] alloc_q;
    logic [`CMPL_ROB_DEPTH-1:0] done_q;
    logic [`CMPL_ROB_DEPTH-1:0] exc_q;
    logic [`CMPL_ROB_DEPTH-1:0] mis_q;
    cmpl_types_pkg::prf_tag_t   dest_q  [`CMPL_ROB_DEPTH];
    cmpl_types_pkg::data_t      value_q [`CMPL_ROB_DEPTH];
    cmpl_types_pkg::rob_idx_t   head_q;

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alloc_q <= '0;
            done_q  <= '0;
            exc_q   <= '0;
            mis_q   <= '0;
            head_q  <= '0;
        end else if (flush_i) begin
            alloc_q <= '0;
            done_q  <= '0;
            head_q  <= '0;
        end else begin
            head_q <= head_idx_i;
            // head moved past an entry, so it has retired
            if (head_q != head_idx_i) begin
                alloc_q[head_q] <= 1'b0;
            end
            for (int l = 0; l < `CMPL_WB_WIDTH; l++) begin
                if (rob_cmpl_i[l].valid) begin
                    done_q[rob_cmpl_i[l].rob_idx] <= 1'b1;
                    exc_q[rob_cmpl_i[l].rob_idx]  <= rob_cmpl_i[l].exception;
                    mis_q[rob_cmpl_i[l].rob_idx]  <= rob_cmpl_i[l].mispred;
                end
            end
            // a freed slot may be reused in the same cycle
            if (alloc_i) begin
                alloc_q[alloc_idx_i] <= 1'b1;
                done_q[alloc_idx_i]  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc_i) begin
            dest_q[alloc_idx_i] <= alloc_dest_prf_i;
        end
        for (int l = 0; l < `CMPL_WB_WIDTH; l++) begin
            if (rob_cmpl_i[l].valid) begin
                value_q[rob_cmpl_i[l].rob_idx] <= rob_cmpl_i[l].value;
            end
        end
    end

    always_comb begin
        head_o.valid     = alloc_q[head_idx_i] && done_q[head_idx_i];
        head_o.rob_idx   = head_idx_i;
        head_o.dest_prf  = dest_q[head_idx_i];
        head_o.value     = value_q[head_idx_i];
        head_o.exception = exc_q[head_idx_i];
        head_o.mispred   = mis_q[head_idx_i];
    end

    for (genvar l = 0; l < `CMPL_WB_WIDTH; l++) begin : g_cmpl_chk
        a_cmpl_allocated: assert property (@(posedge clock) disable iff (!rst_n_i)
            rob_cmpl_i[l].valid |-> alloc_q[rob_cmpl_i[l].rob_idx])
            else $error("rob_done_table: completion for unallocated entry");
    end

endmodule

/* verilog/retire_fsm.sv */
`timescale 1ns/1ps

module retire_fsm (
    input  logic                    clock,
    input  logic                    rst_n_i,
    input  cmpl_types_pkg::retire_t head_i,
    input  logic                    retire_ready_i,
    output cmpl_types_pkg::retire_t retire_o,
    output logic                    retire_strobe_o,
    output logic                    flush_o
);

    rob_ctrl_pkg::retire_state_e state_q;
    rob_ctrl_pkg::retire_state_e state_d;
    cmpl_types_pkg::retire_t     retire_q;
    logic                        load;

    // head_i already shows the next entry during a handshake
    always_comb begin
        state_d = state_q;
        load    = 1'b0;
        case (state_q)
            rob_ctrl_pkg::RT_IDLE: begin
                if (head_i.valid) begin
                    state_d = rob_ctrl_pkg::RT_RETIRE;
                    load    = 1'b1;
                end
            end
            rob_ctrl_pkg::RT_RETIRE: begin
                if (retire_ready_i) begin
                    if (retire_q.exception || retire_q.mispred) begin
                        state_d = rob_ctrl_pkg::RT_FLUSH;
                    end else if (head_i.valid) begin
                        load = 1'b1;
                    end else begin
                        state_d = rob_ctrl_pkg::RT_IDLE;
                    end
                end
            end
            rob_ctrl_pkg::RT_FLUSH: state_d = rob_ctrl_pkg::RT_IDLE;
            default:                state_d = rob_ctrl_pkg::RT_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= rob_ctrl_pkg::RT_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            retire_q <= head_i;
        end
    end

    always_comb begin
        retire_o       = retire_q;
        retire_o.valid = (state_q == rob_ctrl_pkg::RT_RETIRE);
    end

    assign retire_strobe_o = (state_q == rob_ctrl_pkg::RT_RETIRE) && retire_ready_i;
    assign flush_o         = (state_q == rob_ctrl_pkg::RT_FLUSH);

endmodule

/* verilog/completion_subsys.sv */
`timescale 1ns/1ps
`include "cmpl_settings.svh"

module completion_subsys (
    input  logic                                            clock,
    input  logic                                            rst_n_i,
    input  cmpl_types_pkg::fu_result_t [`CMPL_WB_WIDTH-1:0] fu_res_i,
    input  cmpl_types_pkg::lsq_wb_t                         lsq_wb_i,
    output logic                                            lsq_ready_o,
    input  logic                                            alloc_valid_i,
    input  cmpl_types_pkg::prf_tag_t                        alloc_dest_prf_i,
    output logic                                            alloc_ready_o,
    output cmpl_types_pkg::rob_idx_t                        alloc_rob_idx_o,
    input  logic                                            retire_ready_i,
    input  cmpl_types_pkg::wb_m2s_t                         wb_i,
    output cmpl_types_pkg::wb_s2m_t                         wb_o,
    output cmpl_types_pkg::cdb_entry_t [`CMPL_WB_WIDTH-1:0] cdb_o,
    output cmpl_types_pkg::retire_t                         retire_o,
    output logic                                            flush_o
);

    cmpl_types_pkg::prf_wr_t   [`CMPL_WB_WIDTH-1:0] prf_wr;
    cmpl_types_pkg::rob_cmpl_t [`CMPL_WB_WIDTH-1:0] rob_cmpl;
    cmpl_types_pkg::retire_t                        head_entry;
    cmpl_types_pkg::rob_idx_t                       head;
    cmpl_types_pkg::rob_idx_t                       tail;
    cmpl_types_pkg::rob_idx_t                       head_idx;
    logic                                           alloc;
    logic                                           retire_strobe;
    logic                                           full;
    logic                                           empty;

    assign alloc_ready_o   = !full && !flush_o;
    assign alloc           = alloc_valid_i && alloc_ready_o;
    assign alloc_rob_idx_o = tail;

    // look one entry ahead while the current head is handed off
    assign head_idx = head + cmpl_types_pkg::rob_idx_t'(retire_strobe);

    complete_stage complete_i (
        .fu_res_i    (fu_res_i),
        .lsq_wb_i    (lsq_wb_i),
        .lsq_ready_o (lsq_ready_o),
        .prf_wr_o    (prf_wr),
        .rob_cmpl_o  (rob_cmpl),
        .cdb_o       (cdb_o)
    );

    phys_regfile prf_i (
        .clock    (clock),
        .rst_n_i  (rst_n_i),
        .prf_wr_i (prf_wr),
        .wb_i     (wb_i),
        .wb_o     (wb_o)
    );

    rob_ptr_counter ptr_i (
        .clock    (clock),
        .rst_n_i  (rst_n_i),
        .alloc_i  (alloc),
        .retire_i (retire_strobe),
        .flush_i  (flush_o),
        .head_o   (head),
        .tail_o   (tail),
        .full_o   (full),
        .empty_o  (empty)
    );

    rob_done_table done_i (
        .clock            (clock),
        .rst_n_i          (rst_n_i),
        .alloc_i          (alloc),
        .alloc_idx_i      (tail),
        .alloc_dest_prf_i (alloc_dest_prf_i),
        .rob_cmpl_i       (rob_cmpl),
        .flush_i          (flush_o),
        .head_idx_i       (head_idx),
        .head_o           (head_entry)
    );

    retire_fsm fsm_i (
        .clock           (clock),
        .rst_n_i         (rst_n_i),
        .head_i          (head_entry),
        .retire_ready_i  (retire_ready_i),
        .retire_o        (retire_o),
        .retire_strobe_o (retire_strobe),
        .flush_o         (flush_o)
    );

    // pointer occupancy and the done table must agree
    a_empty_no_head: assert property (@(posedge clock) disable iff (!rst_n_i)
        empty |-> !head_entry.valid)
        else $error("completion_subsys: retirable head in an empty ROB");

endmodule

/* verif/completion_checker.sv */
`timescale 1ns/1ps
`include "cmpl_settings.svh"

module completion_checker (
    input logic                                            clock,
    input logic                                            rst_n_i,
    input cmpl_types_pkg::fu_result_t [`CMPL_WB_WIDTH-1:0] fu_res_i,
    input cmpl_types_pkg::lsq_wb_t                         lsq_wb_i,
    input logic                                            lsq_ready_i,
    input logic                                            alloc_valid_i,
    input cmpl_types_pkg::prf_tag_t                        alloc_dest_prf_i,
    input logic                                            alloc_ready_i,
    input cmpl_types_pkg::rob_idx_t                        alloc_rob_idx_i,
    input logic                                            retire_ready_i,
    input cmpl_types_pkg::wb_m2s_t                         wb_m_i,
    input cmpl_types_pkg::wb_s2m_t                         wb_s_i,
    input cmpl_types_pkg::cdb_entry_t [`CMPL_WB_WIDTH-1:0] cdb_i,
    input cmpl_types_pkg::retire_t                         retire_i,
    input logic                                            flush_i
);

    int                       err_count = 0;
    int                       flush_seen = 0;
    cmpl_types_pkg::data_t    prf_m [`CMPL_PHYS_REGS];
    cmpl_types_pkg::prf_tag_t dest_m [`CMPL_ROB_DEPTH];
    cmpl_types_pkg::data_t    val_m [`CMPL_ROB_DEPTH];
    logic                     exc_m [`CMPL_ROB_DEPTH];
    logic                     mis_m [`CMPL_ROB_DEPTH];
    cmpl_types_pkg::rob_idx_t order_q [$];
    cmpl_types_pkg::rob_idx_t tail_m = '0;
    cmpl_types_pkg::retire_t  prev_ret;
    cmpl_types_pkg::prf_tag_t wb_adr;
    logic                     prev_stall = 1'b0;
    logic                     flush_due = 1'b0;
    logic                     wb_pend = 1'b0;
    logic                     wb_we;
    logic                     saw_full = 1'b0;
    logic                     saw_lsq_block = 1'b0;
    logic                     saw_stall = 1'b0;

    initial begin
        for (int r = 0; r < `CMPL_PHYS_REGS; r++) begin
            prf_m[r] = '0;
        end
    end

    task automatic mismatch(input string msg);
        $display("mismatch at time %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic report_coverage();
        if (!saw_full) begin
            $display("the ROB never became full during the run");
            err_count++;
        end
        if (flush_seen < 2) begin
            $display("expected two flushes but saw %0d", flush_seen);
            err_count++;
        end
        if (!saw_lsq_block || !saw_stall) begin
            $display("load back-pressure or a retire stall was never exercised");
            err_count++;
        end
    endtask

    // sampled mid-cycle, where inputs and combinational outputs are settled
    always @(negedge clock) begin
        cmpl_types_pkg::cdb_entry_t [`CMPL_WB_WIDTH-1:0] exp_cdb;
        cmpl_types_pkg::retire_t                         exp_ret;
        cmpl_types_pkg::data_t                           v;
        cmpl_types_pkg::rob_idx_t                        idx;
        logic                                            free_found;
        logic                                            flush_exp;
        if (rst_n_i) begin
            flush_exp  = flush_due;
            exp_cdb    = '0;
            free_found = 1'b0;
            for (int i = 0; i < `CMPL_WB_WIDTH; i++) begin
                if (fu_res_i[i].valid) begin
                    v = (fu_res_i[i].kind == rob_ctrl_pkg::KIND_JUMP) ?
                        fu_res_i[i].link_value : fu_res_i[i].value;
                    exp_cdb[i] = '{valid: 1'b1, phys_tag: fu_res_i[i].dest_prf, value: v};
                    val_m[fu_res_i[i].rob_idx] = v;
                    exc_m[fu_res_i[i].rob_idx] = fu_res_i[i].exception;
                    mis_m[fu_res_i[i].rob_idx] = fu_res_i[i].mispred;
                end else if (!free_found) begin
                    free_found = 1'b1;
                    if (lsq_wb_i.valid) begin
                        exp_cdb[i] = '{valid: 1'b1, phys_tag: lsq_wb_i.dest_prf,
                                       value: lsq_wb_i.data};
                        val_m[lsq_wb_i.rob_idx] = lsq_wb_i.data;
                        exc_m[lsq_wb_i.rob_idx] = 1'b0;
                        mis_m[lsq_wb_i.rob_idx] = 1'b0;
                    end
                end
            end
            if (lsq_ready_i !== free_found) mismatch("lsq_ready_o does not match free lanes");
            if (lsq_wb_i.valid && !free_found) saw_lsq_block = 1'b1;
            if (cdb_i !== exp_cdb) mismatch($sformatf("cdb got %h expected %h", cdb_i, exp_cdb));
            for (int i = 0; i < `CMPL_WB_WIDTH; i++) begin
                if (exp_cdb[i].valid) prf_m[exp_cdb[i].phys_tag] = exp_cdb[i].value;
            end

            // allocation side, before this cycle's retirement frees a slot
            if (alloc_ready_i !== (order_q.size() < `CMPL_ROB_DEPTH && !flush_exp)) begin
                mismatch($sformatf("alloc_ready_o is %b with %0d entries in flight",
                                   alloc_ready_i, order_q.size()));
            end
            if (order_q.size() == `CMPL_ROB_DEPTH) saw_full = 1'b1;
            if (alloc_rob_idx_i !== tail_m) begin
                mismatch($sformatf("alloc index %0d expected %0d", alloc_rob_idx_i, tail_m));
            end

            if (flush_exp !== flush_i) mismatch($sformatf("flush_o is %b", flush_i));
            flush_due = 1'b0;
            if (prev_stall && retire_i !== prev_ret) mismatch("retire_o changed while stalled");
            if (retire_i.valid) begin
                if (order_q.size() == 0) begin
                    mismatch("retirement with nothing in flight");
                end else begin
                    idx     = order_q[0];
                    exp_ret = '{valid: 1'b1, rob_idx: idx, dest_prf: dest_m[idx],
                                value: val_m[idx], exception: exc_m[idx], mispred: mis_m[idx]};
                    if (retire_i !== exp_ret) begin
                        mismatch($sformatf("retire got %h expected %h", retire_i, exp_ret));
                    end
                    if (retire_ready_i) begin
                        void'(order_q.pop_front());
                        flush_due = exc_m[idx] || mis_m[idx];
                    end
                end
            end
            prev_stall = retire_i.valid && !retire_ready_i;
            if (prev_stall) saw_stall = 1'b1;
            prev_ret = retire_i;

            if (alloc_valid_i && alloc_ready_i) begin
                order_q.push_back(tail_m);
                dest_m[tail_m] = alloc_dest_prf_i;
                tail_m = tail_m + 1'b1;
            end
            if (flush_exp) begin
                order_q.delete();
                tail_m = '0;
                flush_seen++;
            end

            // wishbone answer is due one cycle after the request
            if (wb_pend) begin
                if (wb_s_i.ack !== !wb_we || wb_s_i.err !== wb_we) begin
                    mismatch($sformatf("wishbone ack %b err %b for we %b",
                                       wb_s_i.ack, wb_s_i.err, wb_we));
                end else if (!wb_we && wb_s_i.dat !== prf_m[wb_adr]) begin
                    mismatch($sformatf("register %0d read %h expected %h",
                                       wb_adr, wb_s_i.dat, prf_m[wb_adr]));
                end
                wb_pend = 1'b0;
            end else if (wb_m_i.cyc && wb_m_i.stb) begin
                wb_pend = 1'b1;
                wb_we   = wb_m_i.we;
                wb_adr  = wb_m_i.adr;
            end else if (wb_s_i.ack || wb_s_i.err) begin
                mismatch("wishbone response without a request");
            end
        end
    end

endmodule

/* verif/tb_completion.sv */
`timescale 1ns/1ps
`include "cmpl_settings.svh"

module tb_completion;

    typedef struct packed {
        logic                                            alloc;
        cmpl_types_pkg::prf_tag_t                        dest;
        cmpl_types_pkg::fu_result_t [`CMPL_WB_WIDTH-1:0] fu;
        cmpl_types_pkg::lsq_wb_t                         lsq;
        logic                                            rand_rdy;
    } row_t;

    localparam int N_ROWS = 60;

    logic                                            clock;
    logic                                            rst_n;
    cmpl_types_pkg::fu_result_t [`CMPL_WB_WIDTH-1:0] fu_res;
    cmpl_types_pkg::lsq_wb_t                         lsq_wb;
    logic                                            lsq_ready;
    logic                                            alloc_valid;
    cmpl_types_pkg::prf_tag_t                        alloc_dest;
    logic                                            alloc_ready;
    cmpl_types_pkg::rob_idx_t                        alloc_rob_idx;
    logic                                            retire_ready;
    cmpl_types_pkg::wb_m2s_t                         wb_m;
    cmpl_types_pkg::wb_s2m_t                         wb_s;
    cmpl_types_pkg::cdb_entry_t [`CMPL_WB_WIDTH-1:0] cdb;
    cmpl_types_pkg::retire_t                         retire;
    logic                                            flush;
    row_t                                            tbl [N_ROWS];
    int                                              seed;
    int                                              timeouts;

    completion_subsys dut_i (
        .clock            (clock),
        .rst_n_i          (rst_n),
        .fu_res_i         (fu_res),
        .lsq_wb_i         (lsq_wb),
        .lsq_ready_o      (lsq_ready),
        .alloc_valid_i    (alloc_valid),
        .alloc_dest_prf_i (alloc_dest),
        .alloc_ready_o    (alloc_ready),
        .alloc_rob_idx_o  (alloc_rob_idx),
        .retire_ready_i   (retire_ready),
        .wb_i             (wb_m),
        .wb_o             (wb_s),
        .cdb_o            (cdb),
        .retire_o         (retire),
        .flush_o          (flush)
    );

    completion_checker chk_i (
        .clock            (clock),
        .rst_n_i          (rst_n),
        .fu_res_i         (fu_res),
        .lsq_wb_i         (lsq_wb),
        .lsq_ready_i      (lsq_ready),
        .alloc_valid_i    (alloc_valid),
        .alloc_dest_prf_i (alloc_dest),
        .alloc_ready_i    (alloc_ready),
        .alloc_rob_idx_i  (alloc_rob_idx),
        .retire_ready_i   (retire_ready),
        .wb_m_i           (wb_m),
        .wb_s_i           (wb_s),
        .cdb_i            (cdb),
        .retire_i         (retire),
        .flush_i          (flush)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic put_lane(input int r, input int l, input logic jump, input int rob,
                            input int dest, input logic exc, input logic mis);
        tbl[r].fu[l].valid      = 1'b1;
        tbl[r].fu[l].kind       = jump ? rob_ctrl_pkg::KIND_JUMP : rob_ctrl_pkg::KIND_ALU;
        tbl[r].fu[l].rob_idx    = rob;
        tbl[r].fu[l].dest_prf   = dest;
        tbl[r].fu[l].value      = 32'h1000_0000 | (dest << 8) | rob;
        tbl[r].fu[l].link_value = 32'h8000_0000 | dest;
        tbl[r].fu[l].exception  = exc;
        tbl[r].fu[l].mispred    = mis;
    endtask

    task automatic put_load(input int r, input int rob, input int dest);
        tbl[r].lsq = '{valid: 1'b1, rob_idx: rob, dest_prf: dest, data: 32'h4000_0000 | dest};
    endtask

    task automatic build_table();
        for (int r = 0; r < N_ROWS; r++) begin
            tbl[r] = '0;
            tbl[r].rand_rdy = (r <= 24);
        end
        // eight entries, then mixed completions with a load
        for (int r = 0; r < 8; r++) begin
            tbl[r].alloc = 1'b1;
            tbl[r].dest  = 10 + r;
        end
        put_lane(8, 0, 1'b0, 0, 10, 1'b0, 1'b0);
        put_lane(8, 2, 1'b1, 1, 11, 1'b0, 1'b0);
        put_load(8, 2, 12);
        // all lanes busy, the load must wait a cycle
        put_lane(9, 0, 1'b0, 3, 13, 1'b0, 1'b0);
        put_lane(9, 1, 1'b0, 4, 14, 1'b0, 1'b0);
        put_lane(9, 2, 1'b1, 5, 15, 1'b0, 1'b0);
        put_lane(9, 3, 1'b0, 6, 16, 1'b0, 1'b0);
        put_load(9, 7, 17);
        put_load(10, 7, 17);
        // keep allocating until the ROB fills
        for (int r = 11; r <= 40; r++) begin
            tbl[r].alloc = 1'b1;
            tbl[r].dest  = 20 + (r % 16);
        end
        put_lane(41, 0, 1'b0, 8, 40, 1'b0, 1'b0);
        put_lane(41, 1, 1'b0, 9, 41, 1'b0, 1'b1);
        // after the flush, allocation restarts at entry 0
        tbl[50].alloc = 1'b1;
        tbl[50].dest  = 50;
        tbl[51].alloc = 1'b1;
        tbl[51].dest  = 51;
        put_lane(52, 0, 1'b1, 0, 50, 1'b1, 1'b0);
        put_lane(52, 1, 1'b0, 1, 51, 1'b0, 1'b0);
    endtask

    task automatic wb_access(input logic we, input int adr);
        int n;
        wb_m <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: cmpl_types_pkg::prf_tag_t'(adr),
                  dat: 32'h5a5a_0000};
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!(wb_s.ack || wb_s.err) && n < 20);
        if (n >= 20) begin
            $display("timeout waiting for a wishbone answer on register %0d", adr);
            timeouts++;
        end
        @(posedge clock);
        wb_m <= '0;
        @(posedge clock);
    endtask

    initial begin
        int   n;
        logic rdy_bit;
        int   read_list [13] = '{10, 11, 12, 13, 14, 15, 16, 17, 40, 41, 50, 51, 0};
        seed         = 14;
        timeouts     = 0;
        rst_n        = 1'b0;
        fu_res       = '0;
        lsq_wb       = '0;
        alloc_valid  = 1'b0;
        alloc_dest   = '0;
        retire_ready = 1'b0;
        wb_m         = '0;
        build_table();
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
        for (int r = 0; r < N_ROWS; r++) begin
            @(posedge clock);
            rdy_bit = tbl[r].rand_rdy ? ($random(seed) % 2 != 0) : 1'b1;
            alloc_valid  <= tbl[r].alloc;
            alloc_dest   <= tbl[r].dest;
            fu_res       <= tbl[r].fu;
            lsq_wb       <= tbl[r].lsq;
            retire_ready <= rdy_bit;
        end
        @(posedge clock);
        alloc_valid  <= 1'b0;
        fu_res       <= '0;
        lsq_wb       <= '0;
        retire_ready <= 1'b1;
        // drain whatever is still retiring or flushing
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while ((retire.valid || flush) && n < 100);
        if (n >= 100) begin
            $display("timeout waiting for the retire stream to drain");
            timeouts++;
        end
        @(posedge clock);
        foreach (read_list[i]) begin
            wb_access(1'b0, read_list[i]);
        end
        wb_access(1'b1, 10);
        wb_access(1'b0, 10);
        repeat (2) @(posedge clock);
        chk_i.report_coverage();
        $display("errors: %0d mismatches, %0d timeouts", chk_i.err_count, timeouts);
        if (chk_i.err_count == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
verilog/rob_ctrl_pkg.sv
verilog/cmpl_types_pkg.sv
verilog/complete_stage.sv
verilog/phys_regfile.sv
verilog/rob_ptr_counter.sv
verilog/rob_done_table.sv
verilog/retire_fsm.sv
verilog/completion_subsys.sv
verif/completion_checker.sv
verif/tb_completion.sv
